// File: verilog/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// Copier header prepended to cartridge and cheat files
`define CART_HDR_OFFSET         512
`define CART_HDR_MIN_ADDR       510

// Internal header fields per mapping, offset included
`define CART_LOROM_SIZE_ADDR    ('h7FD6 + `CART_HDR_OFFSET)
`define CART_LOROM_RAM_ADDR     ('h7FD8 + `CART_HDR_OFFSET)
`define CART_HIROM_SIZE_ADDR    ('hFFD6 + `CART_HDR_OFFSET)
`define CART_HIROM_RAM_ADDR     ('hFFD8 + `CART_HDR_OFFSET)
`define CART_EXHIROM_SIZE_ADDR  ('h40FFD6 + `CART_HDR_OFFSET)
`define CART_EXHIROM_RAM_ADDR   ('h40FFD8 + `CART_HDR_OFFSET)

// Size code n means CART_SIZE_BASE << n bytes
`define CART_SIZE_BASE          1024
`define CART_DEFAULT_ROM_SIZE   12

`define CART_SECTOR_SHIFT       9
`define CART_ADDR_W             25
`define CART_MASK_W             24

`endif

// File: verilog/loader_pkg.sv
package loader_pkg;

	// Host download slot number
	typedef logic [7:0] dl_index_t;

	// Slot used for cheat files, every other slot is a cartridge
	localparam dl_index_t DL_INDEX_CHEAT = 8'd3;

	// ROM header interpretation chosen in the menu
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

endpackage

// File: verilog/cheat_pkg.sv
package cheat_pkg;

	// One cheat code, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Two download words per field, index 1 is the upper half
	typedef logic [1:0][15:0] slot_pair_t;

	// Download word k lands in slots[k/2][k%2]
	typedef union packed {
		cheat_fields_t     fields;
		slot_pair_t [0:3]  slots;
	} cheat_code_u;

endpackage

// File: verilog/download_if.sv
`timescale 1ns/1ps
`include "cart_params.svh"

interface download_if;

	logic [`CART_ADDR_W-1:0] addr;
	logic [15:0]             data;
	// Single-cycle write strobe
	logic                    wr;
	// Levels, at most one high at a time
	logic                    cart_active;
	logic                    code_active;

	modport router (
		output addr, data, wr, cart_active, code_active
	);

	modport sink (
		input addr, data, wr, cart_active, code_active
	);

endinterface

// File: verilog/download_router.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module download_router (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  loader_pkg::dl_index_t   ioctl_index,
	input  logic [`CART_ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]             ioctl_dout,
	input  logic                    ioctl_wr,
	download_if.router              dl,
	input  logic                    loading,
	output logic                    cart_start,
	output logic                    cart_end,
	output logic                    system_hold
);
	import loader_pkg::*;

	logic code_index;
	logic cart_active;
	logic cart_active_q;

	// Cheat files arrive on their own slot
	assign code_index  = (ioctl_index == DL_INDEX_CHEAT);
	assign cart_active = ioctl_download & ~code_index;

	assign dl.addr        = ioctl_addr;
	assign dl.data        = ioctl_dout;
	assign dl.wr          = ioctl_wr;
	assign dl.cart_active = cart_active;
	assign dl.code_active = ioctl_download & code_index;

	// Edge pulses of the cartridge download
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cart_active_q <= 1'b0;
			cart_start    <= 1'b0;
			cart_end      <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			cart_start    <= cart_active & ~cart_active_q;
			cart_end      <= ~cart_active & cart_active_q;
		end
	end

	// Console stays in reset while the cartridge or its backup RAM is loading
	assign system_hold = ~reset | cart_active | loading;

endmodule

// File: verilog/rom_header_detect.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module rom_header_detect (
	input  logic                     clk_sys,
	input  logic                     reset,
	download_if.sink                 dl,
	input  loader_pkg::header_mode_t header_mode,
	output logic [7:0]               rom_type,
	output logic [`CART_MASK_W-1:0]  rom_mask,
	output logic [`CART_MASK_W-1:0]  ram_mask,
	output logic                     rom_region
);
	import loader_pkg::*;

	localparam logic [`CART_MASK_W-1:0] SIZE_BASE = `CART_SIZE_BASE;

	logic [3:0]              rom_size;
	logic [3:0]              ram_size;
	logic                    forced;
	logic [`CART_ADDR_W-1:0] size_addr;
	logic [`CART_ADDR_W-1:0] ram_addr;

	// Internal header location of the forced mapping
	always_comb begin
		forced    = 1'b1;
		size_addr = `CART_ADDR_W'(`CART_LOROM_SIZE_ADDR);
		ram_addr  = `CART_ADDR_W'(`CART_LOROM_RAM_ADDR);
		case (header_mode)
			HDR_HIROM: begin
				size_addr = `CART_ADDR_W'(`CART_HIROM_SIZE_ADDR);
				ram_addr  = `CART_ADDR_W'(`CART_HIROM_RAM_ADDR);
			end
			HDR_EXHIROM: begin
				size_addr = `CART_ADDR_W'(`CART_EXHIROM_SIZE_ADDR);
				ram_addr  = `CART_ADDR_W'(`CART_EXHIROM_RAM_ADDR);
			end
			HDR_LOROM: forced = 1'b1;
			default:   forced = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size   <= 4'(`CART_DEFAULT_ROM_SIZE);
			ram_size   <= 4'd0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
		end else if (dl.cart_active && dl.wr) begin
			// Leading word of the copier header
			if (dl.addr == '0) begin
				rom_size <= 4'(`CART_DEFAULT_ROM_SIZE);
				ram_size <= 4'd0;
				if (header_mode == HDR_AUTO && dl.data[7:0] != 8'd0)
					{ram_size, rom_size} <= dl.data[7:0];
				case (header_mode)
					HDR_NONE, HDR_LOROM: rom_type <= 8'd0;
					HDR_HIROM:           rom_type <= 8'd1;
					HDR_EXHIROM:         rom_type <= 8'd2;
					default:             rom_type <= dl.data[15:8];
				endcase
			end
			if (dl.addr == `CART_ADDR_W'(2))
				rom_region <= dl.data[8];
			if (forced && dl.addr == size_addr)
				rom_size <= dl.data[11:8];
			if (forced && dl.addr == ram_addr)
				ram_size <= dl.data[3:0];
		end
	end

	assign rom_mask = (SIZE_BASE << rom_size) - `CART_MASK_W'd1;
	// No backup RAM at all for code 0
	assign ram_mask = (ram_size != 4'd0) ? (SIZE_BASE << ram_size) - `CART_MASK_W'd1 : '0;

endmodule

// File: verilog/cheat_code_loader.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module cheat_code_loader (
	input  logic                   clk_sys,
	input  logic                   reset,
	download_if.sink               dl,
	output cheat_pkg::cheat_fields_t cheat_code,
	output logic                   cheat_load
);
	import cheat_pkg::*;

	cheat_code_u             code_q;
	logic [`CART_ADDR_W-1:0] code_off;
	logic [2:0]              slot_sel;
	logic                    accept;

	// Code words follow the copier header
	assign code_off = dl.addr - `CART_ADDR_W'(`CART_HDR_OFFSET);
	assign slot_sel = code_off[3:1];
	assign accept   = dl.code_active & dl.wr & (dl.addr > `CART_ADDR_W'(`CART_HDR_MIN_ADDR));

	// Slot pair picks the field, low bit picks the half
	always_ff @(posedge clk_sys) begin
		if (accept)
			code_q.slots[slot_sel[2:1]][slot_sel[0]] <= dl.data;
	end

	// Last word completes the code
	always_ff @(posedge clk_sys) begin
		if (!reset)
			cheat_load <= 1'b0;
		else
			cheat_load <= accept & (slot_sel == 3'd7);
	end

	assign cheat_code = code_q.fields;

endmodule

// File: verilog/backup_ram_sequencer.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module backup_ram_sequencer (
	input  logic                    clk_sys,
	input  logic                    reset,
	download_if.sink                dl,
	input  logic                    cart_start,
	input  logic                    cart_end,
	input  logic [`CART_MASK_W-1:0] ram_mask,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic [63:0]             img_size,
	input  logic                    bk_load,
	input  logic                    bk_save,
	input  logic                    sd_ack,
	output logic [31:0]             sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	output logic                    bk_ena,
	output logic                    loading,
	output logic                    busy
);

	typedef enum logic {
		ST_IDLE,
		ST_ACTIVE
	} state_t;

	state_t      state;
	logic        load_req;
	logic        save_req;
	logic        load_q;
	logic        save_q;
	logic        ack_q;
	logic        ack_old;
	logic        ack_rise;
	logic        ack_fall;
	logic [31:0] last_lba;

	// ======================================================================
	// Backup enable
	// ======================================================================

	// Save image gets mounted while the cartridge is still downloading
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_ena <= 1'b0;
		end else begin
			if (cart_start)
				bk_ena <= 1'b0;
			if (dl.cart_active && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
		end
	end

	// ======================================================================
	// Sector transfer
	// ======================================================================

	assign load_req = bk_load & bk_ena;
	assign save_req = bk_save & bk_ena;
	assign ack_rise = ack_q & ~ack_old;
	assign ack_fall = ~ack_q & ack_old;
	assign last_lba = 32'(ram_mask >> `CART_SECTOR_SHIFT);

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state   <= ST_IDLE;
			load_q  <= 1'b0;
			save_q  <= 1'b0;
			ack_q   <= 1'b0;
			ack_old <= 1'b0;
			loading <= 1'b0;
			sd_lba  <= 32'd0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
		end else begin
			load_q  <= load_req;
			save_q  <= save_req;
			ack_q   <= sd_ack;
			ack_old <= ack_q;

			// Storage has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if ((load_req & ~load_q) | (save_req & ~save_q)) begin
						state   <= ST_ACTIVE;
						loading <= load_req;
						sd_lba  <= 32'd0;
						sd_rd   <= load_req;
						sd_wr   <= ~load_req;
					end
					// Restore the save file once the cartridge is in
					if (cart_end && bk_ena && |img_size) begin
						state   <= ST_ACTIVE;
						loading <= 1'b1;
						sd_lba  <= 32'd0;
						sd_rd   <= 1'b1;
						sd_wr   <= 1'b0;
					end
				end
				default: begin
					if (ack_fall) begin
						if (sd_lba >= last_lba) begin
							state   <= ST_IDLE;
							loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= loading;
							sd_wr  <= ~loading;
						end
					end
				end
			endcase
		end
	end

	assign busy = (state == ST_ACTIVE);

endmodule

// File: verilog/cart_loader_top.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module cart_loader_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  loader_pkg::dl_index_t    ioctl_index,
	input  logic [`CART_ADDR_W-1:0]  ioctl_addr,
	input  logic [15:0]              ioctl_dout,
	input  logic                     ioctl_wr,
	input  loader_pkg::header_mode_t header_mode,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic [63:0]              img_size,
	input  logic                     bk_load,
	input  logic                     bk_save,
	input  logic                     sd_ack,
	output logic [7:0]               rom_type,
	output logic [`CART_MASK_W-1:0]  rom_mask,
	output logic [`CART_MASK_W-1:0]  ram_mask,
	output logic                     rom_region,
	output logic [31:0]              cheat_flags,
	output logic [31:0]              cheat_address,
	output logic [31:0]              cheat_compare,
	output logic [31:0]              cheat_replace,
	output logic                     cheat_load,
	output logic [31:0]              sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic                     bk_ena,
	output logic                     bk_busy,
	output logic                     system_hold
);
	import cheat_pkg::*;

	cheat_fields_t cheat_code;
	logic          cart_start;
	logic          cart_end;
	logic          loading;

	download_if dl_bus ();

	download_router u_router (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.ioctl_wr, .dl(dl_bus.router), .loading, .cart_start, .cart_end, .system_hold
	);

	rom_header_detect u_header (
		.clk_sys, .reset, .dl(dl_bus.sink), .header_mode,
		.rom_type, .rom_mask, .ram_mask, .rom_region
	);

	cheat_code_loader u_cheat (
		.clk_sys, .reset, .dl(dl_bus.sink), .cheat_code, .cheat_load
	);

	backup_ram_sequencer u_backup (
		.clk_sys, .reset, .dl(dl_bus.sink), .cart_start, .cart_end, .ram_mask,
		.img_mounted, .img_readonly, .img_size, .bk_load, .bk_save, .sd_ack,
		.sd_lba, .sd_rd, .sd_wr, .bk_ena, .loading, .busy(bk_busy)
	);

	assign cheat_flags   = cheat_code.flags;
	assign cheat_address = cheat_code.address;
	assign cheat_compare = cheat_code.compare;
	assign cheat_replace = cheat_code.replace;

endmodule

// File: testbench/cart_loader_properties.sv
`timescale 1ns/1ps

module cart_loader_properties (
	input logic        clk_sys,
	input logic        reset,
	input logic        sd_rd,
	input logic        sd_wr,
	input logic        sd_ack,
	input logic        busy,
	input logic [31:0] sd_lba,
	input logic        cheat_load
);

	int unsigned violations = 0;

	// One direction per sector request
	request_exclusive: assert property (@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr))
	else begin
		violations++;
		$error("sd_rd and sd_wr are both high");
	end

	// Completed code is announced once
	load_single: assert property (@(posedge clk_sys) disable iff (!reset)
		cheat_load |=> !cheat_load)
	else begin
		violations++;
		$error("cheat_load stayed high for more than one cycle");
	end

	// Sector number moves at a transfer start or two cycles after the acknowledge drops
	lba_steps: assert property (@(posedge clk_sys) disable iff (!reset)
		$changed(sd_lba) |-> $rose(busy) || ($past(sd_ack, 3) && !$past(sd_ack, 2)))
	else begin
		violations++;
		$error("sd_lba changed outside a sector step");
	end

endmodule

bind backup_ram_sequencer cart_loader_properties seq_props (
	.clk_sys, .reset, .sd_rd, .sd_wr, .sd_ack, .busy, .sd_lba, .cheat_load(1'b0)
);

bind cheat_code_loader cart_loader_properties code_props (
	.clk_sys, .reset, .sd_rd(1'b0), .sd_wr(1'b0), .sd_ack(1'b0), .busy(1'b0),
	.sd_lba(32'd0), .cheat_load
);

// File: testbench/tb_cart_loader.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module tb_cart_loader;
	import loader_pkg::*;

	// A sector takes about 12 cycles, so two 16-sector transfers and the
	// downloads stay far below this
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk_sys = 1'b0;
	logic hold_watch = 1'b0;
	logic reset, ioctl_download, ioctl_wr, sd_ack, img_mounted, img_readonly;
	logic bk_load, bk_save, rom_region, cheat_load, sd_rd, sd_wr, bk_ena, bk_busy;
	logic system_hold;
	dl_index_t ioctl_index;
	header_mode_t header_mode;
	logic [`CART_ADDR_W-1:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic [63:0] img_size;
	logic [7:0] rom_type;
	logic [`CART_MASK_W-1:0] rom_mask, ram_mask;
	logic [31:0] cheat_flags, cheat_address, cheat_compare, cheat_replace, sd_lba;
	int seed = 38;
	int cycles = 0;
	int rd_count, wr_count, load_pulses;
	logic [31:0] next_lba;
	logic [15:0] words [8];
	logic [15:0] hdr;
	logic [3:0] rom_code, ram_code;

	cart_loader_top dut0 (.*);

	// ====================================================================
	// Expected values and checks
	// ====================================================================

	// Size code n covers 1 KiB shifted left by n
	function automatic logic [`CART_MASK_W-1:0] size_mask(input logic [3:0] code);
		return `CART_MASK_W'((32'(`CART_SIZE_BASE) << code) - 32'd1);
	endfunction

	function automatic logic [`CART_MASK_W-1:0] backup_mask(input logic [3:0] code);
		return (code == 4'd0) ? '0 : size_mask(code);
	endfunction

	function automatic int protocol_errors();
		return dut0.u_backup.seq_props.violations + dut0.u_cheat.code_props.violations;
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		assert (actual === expected) else begin
			$display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// ====================================================================
	// Stimulus and storage side
	// ====================================================================

	task automatic write_word(input int addr, input logic [15:0] data);
		@(negedge clk_sys);
		ioctl_addr = `CART_ADDR_W'(addr);
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic download(input logic on, input dl_index_t index);
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = on;
	endtask

	// Acknowledge 3 cycles after the request, held for 4 cycles
	task automatic serve_request();
		@(negedge clk_sys);
		if (sd_rd || sd_wr) begin
			check_value("sd_lba", sd_lba, next_lba);
			next_lba = next_lba + 32'd1;
			if (sd_rd)
				rd_count++;
			else
				wr_count++;
			repeat (3) @(negedge clk_sys);
			sd_ack = 1'b1;
			repeat (4) @(negedge clk_sys);
			sd_ack = 1'b0;
		end
	endtask

	task automatic wait_transfer();
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy)
			@(negedge clk_sys);
	endtask

	task automatic forced_header(input header_mode_t mode, input int size_addr,
			input int ram_addr, input logic [7:0] exp_type);
		header_mode = mode;
		rom_code    = 4'($random(seed));
		ram_code    = 4'($random(seed));
		download(1'b1, 8'd0);
		// Nonzero low byte that only auto mode would use
		write_word(0, 16'($random(seed)) | 16'h0001);
		write_word(size_addr, {4'($random(seed)), rom_code, 8'($random(seed))});
		write_word(ram_addr, {12'($random(seed)), ram_code});
		download(1'b0, 8'd0);
		check_value("rom_type", rom_type, exp_type);
		check_value("rom_mask", rom_mask, size_mask(rom_code));
		check_value("ram_mask", ram_mask, backup_mask(ram_code));
	endtask

	initial begin
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		forever serve_request();
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$fatal(1);
		end
		// Console hold follows the cartridge download and the backup load
		if (hold_watch)
			check_value("system_hold", system_hold, ioctl_download | bk_busy);
	end

	always @(negedge clk_sys) begin
		if (cheat_load)
			load_pulses++;
		if (protocol_errors() != 0) begin
			$display("A bound protocol assertion failed at %0t ns", $time);
			$display("Test failures found");
			$fatal(1);
		end
	end

	// ====================================================================
	// Test sequence
	// ====================================================================

	initial begin
		reset          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_dout     = 16'd0;
		ioctl_wr       = 1'b0;
		header_mode    = HDR_AUTO;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = 64'd0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		sd_ack         = 1'b0;
		load_pulses    = 0;
		repeat (2) @(negedge clk_sys);
		check_value("system_hold", system_hold, 1'b1);
		reset = 1'b1;
		@(negedge clk_sys);
		check_value("sd_rd", sd_rd, 1'b0);
		check_value("sd_wr", sd_wr, 1'b0);
		check_value("bk_busy", bk_busy, 1'b0);
		check_value("bk_ena", bk_ena, 1'b0);
		check_value("cheat_load", cheat_load, 1'b0);
		check_value("rom_region", rom_region, 1'b0);
		check_value("rom_mask", rom_mask, (64'd1 << 22) - 64'd1);
		check_value("ram_mask", ram_mask, 64'd0);

		// Auto mode reads the copier header word
		download(1'b1, 8'd0);
		hdr = 16'($random(seed));
		if (hdr[7:0] == 8'd0)
			hdr[7:0] = 8'h01;
		write_word(0, hdr);
		write_word(2, 16'($random(seed)) | 16'h0100);
		download(1'b0, 8'd0);
		check_value("rom_type", rom_type, hdr[15:8]);
		check_value("rom_mask", rom_mask, size_mask(hdr[3:0]));
		check_value("ram_mask", ram_mask, backup_mask(hdr[7:4]));
		check_value("rom_region", rom_region, 1'b1);

		forced_header(HDR_LOROM, `CART_LOROM_SIZE_ADDR, `CART_LOROM_RAM_ADDR, 8'd0);
		forced_header(HDR_EXHIROM, `CART_EXHIROM_SIZE_ADDR, `CART_EXHIROM_RAM_ADDR, 8'd2);

		// Cheat words, then a stray write below the header end
		download(1'b1, 8'd3);
		load_pulses = 0;
		for (int k = 0; k < 8; k++) begin
			words[k] = 16'($random(seed));
			write_word(512 + 2 * k, words[k]);
		end
		check_value("cheat_load", cheat_load, 1'b1);
		write_word(500, 16'($random(seed)));
		download(1'b0, 8'd3);
		check_value("cheat_load pulses", load_pulses, 1);
		check_value("cheat_flags", cheat_flags, {words[1], words[0]});
		check_value("cheat_address", cheat_address, {words[3], words[2]});
		check_value("cheat_compare", cheat_compare, {words[5], words[4]});
		check_value("cheat_replace", cheat_replace, {words[7], words[6]});

		// Manual save of an 8 KiB backup RAM
		header_mode  = HDR_AUTO;
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		download(1'b1, 8'd0);
		write_word(0, {8'($random(seed)), 4'd3, 4'($random(seed))});
		download(1'b0, 8'd0);
		img_mounted = 1'b0;
		@(negedge clk_sys);
		check_value("bk_ena", bk_ena, 1'b1);
		check_value("ram_mask", ram_mask, backup_mask(4'd3));
		rd_count = 0;
		wr_count = 0;
		next_lba = 32'd0;
		bk_save  = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		wait_transfer();
		check_value("write requests", wr_count,
			(backup_mask(4'd3) >> `CART_SECTOR_SHIFT) + 1);
		check_value("read requests", rd_count, 0);
		check_value("sd_lba", sd_lba, 32'd15);

		// Load request before the backup is enabled, then automatic load
		download(1'b1, 8'd0);
		hold_watch = 1'b1;
		repeat (3) @(negedge clk_sys);
		check_value("bk_ena", bk_ena, 1'b0);
		bk_load = 1'b1;
		@(negedge clk_sys);
		bk_load = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("bk_busy", bk_busy, 1'b0);
		check_value("sd_rd", sd_rd, 1'b0);
		img_mounted = 1'b1;
		img_size    = 64'd8192;
		write_word(0, {8'($random(seed)), 4'd3, 4'($random(seed))});
		@(negedge clk_sys);
		check_value("bk_ena", bk_ena, 1'b1);
		rd_count = 0;
		wr_count = 0;
		next_lba = 32'd0;
		download(1'b0, 8'd0);
		img_mounted = 1'b0;
		wait_transfer();
		hold_watch = 1'b0;
		check_value("read requests", rd_count, 16);
		check_value("write requests", wr_count, 0);
		check_value("sd_lba", sd_lba, 32'd15);

		repeat (2) @(negedge clk_sys);
		if (protocol_errors() == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1);
		end
	end

endmodule

// File: build.f
+incdir+verilog
verilog/loader_pkg.sv
verilog/cheat_pkg.sv
verilog/download_if.sv
verilog/download_router.sv
verilog/rom_header_detect.sv
verilog/cheat_code_loader.sv
verilog/backup_ram_sequencer.sv
verilog/cart_loader_top.sv
testbench/cart_loader_properties.sv
testbench/tb_cart_loader.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_cart_loader
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
